/* sim.f */
+incdir+dv
source/dec_pkg.sv
source/dec_stream_if.sv
source/dec_dispatch.sv
source/dec_classify.sv
source/dec_lane.sv
source/dec_collect.sv
source/rv_decode_top.sv
dv/tb_decode.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_decode
LINT_TOP   ?= rv_decode_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Done: no errors" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/decode_model.svh */
// reference decode model and xorshift generator for the decode testbench
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// sign extension from the given width
function automatic logic [63:0] sext(input logic [31:0] v, input int bits);
  logic [63:0] r;
  r = {32'b0, v};
  for (int i = bits; i < 64; i++) begin
    r[i] = v[bits-1];
  end
  return r;
endfunction

function automatic dec_pkg::op_e ref_op(input logic [31:0] inst);
  logic [6:0]   opc;
  logic [2:0]   f3;
  logic         alt;
  dec_pkg::op_e op;
  // the two low opcode bits are not decoded
  opc = {inst[6:2], 2'b11};
  f3  = inst[14:12];
  alt = inst[30];
  op  = dec_pkg::OP_ILLEGAL;
  case (opc)
    dec_pkg::OPC_LUI:   op = dec_pkg::OP_LUI;
    dec_pkg::OPC_AUIPC: op = dec_pkg::OP_AUIPC;
    dec_pkg::OPC_JAL:   op = dec_pkg::OP_JAL;
    dec_pkg::OPC_JALR:  op = (f3 == 3'b000) ? dec_pkg::OP_JALR : dec_pkg::OP_ILLEGAL;
    dec_pkg::OPC_BRANCH: begin
      op = (f3[2:1] == 2'b01) ? dec_pkg::OP_ILLEGAL :
           f3[2] ? dec_pkg::op_e'(6'(dec_pkg::OP_BLT) + 6'(f3[1:0])) :
                   dec_pkg::op_e'(6'(dec_pkg::OP_BEQ) + 6'(f3[0]));
    end
    dec_pkg::OPC_LOAD: begin
      op = (f3 == 3'b111) ? dec_pkg::OP_ILLEGAL :
           dec_pkg::op_e'(6'(dec_pkg::OP_LB) + 6'(f3));
    end
    dec_pkg::OPC_STORE: begin
      op = f3[2] ? dec_pkg::OP_ILLEGAL : dec_pkg::op_e'(6'(dec_pkg::OP_SB) + 6'(f3[1:0]));
    end
    dec_pkg::OPC_OPIMM: begin
      case (f3)
        3'b000:  op = dec_pkg::OP_ADDI;
        3'b001:  op = dec_pkg::OP_SLLI;
        3'b010:  op = dec_pkg::OP_SLTI;
        3'b011:  op = dec_pkg::OP_SLTIU;
        3'b100:  op = dec_pkg::OP_XORI;
        3'b101:  op = alt ? dec_pkg::OP_SRAI : dec_pkg::OP_SRLI;
        3'b110:  op = dec_pkg::OP_ORI;
        default: op = dec_pkg::OP_ANDI;
      endcase
    end
    dec_pkg::OPC_OP: begin
      case (f3)
        3'b000:  op = alt ? dec_pkg::OP_SUB : dec_pkg::OP_ADD;
        3'b001:  op = dec_pkg::OP_SLL;
        3'b010:  op = dec_pkg::OP_SLT;
        3'b011:  op = dec_pkg::OP_SLTU;
        3'b100:  op = dec_pkg::OP_XOR;
        3'b101:  op = alt ? dec_pkg::OP_SRA : dec_pkg::OP_SRL;
        3'b110:  op = dec_pkg::OP_OR;
        default: op = dec_pkg::OP_AND;
      endcase
    end
    dec_pkg::OPC_OPIMM32: begin
      case (f3)
        3'b000:  op = dec_pkg::OP_ADDIW;
        3'b001:  op = dec_pkg::OP_SLLIW;
        3'b101:  op = alt ? dec_pkg::OP_SRAIW : dec_pkg::OP_SRLIW;
        default: op = dec_pkg::OP_ILLEGAL;
      endcase
    end
    dec_pkg::OPC_OP32: begin
      case (f3)
        3'b000:  op = alt ? dec_pkg::OP_SUBW : dec_pkg::OP_ADDW;
        3'b001:  op = dec_pkg::OP_SLLW;
        3'b101:  op = alt ? dec_pkg::OP_SRAW : dec_pkg::OP_SRLW;
        default: op = dec_pkg::OP_ILLEGAL;
      endcase
    end
    default: op = dec_pkg::OP_ILLEGAL;
  endcase
  return op;
endfunction

// format follows from the operation group
function automatic dec_pkg::fmt_e ref_fmt(input dec_pkg::op_e op);
  if (op == dec_pkg::OP_ILLEGAL) begin
    return dec_pkg::FMT_NONE;
  end else if (op inside {dec_pkg::OP_LUI, dec_pkg::OP_AUIPC}) begin
    return dec_pkg::FMT_U;
  end else if (op == dec_pkg::OP_JAL) begin
    return dec_pkg::FMT_J;
  end else if (op inside {[dec_pkg::OP_BEQ : dec_pkg::OP_BGEU]}) begin
    return dec_pkg::FMT_B;
  end else if (op inside {[dec_pkg::OP_SB : dec_pkg::OP_SD]}) begin
    return dec_pkg::FMT_S;
  end else if (op inside {[dec_pkg::OP_ADD : dec_pkg::OP_AND],
                          [dec_pkg::OP_ADDW : dec_pkg::OP_SRAW]}) begin
    return dec_pkg::FMT_R;
  end else begin
    return dec_pkg::FMT_I;
  end
endfunction

function automatic dec_pkg::dec_pkt_t decode_ref(input logic [31:0] inst,
                                                 input logic [63:0] pc,
                                                 input logic [63:0] a,
                                                 input logic [63:0] b);
  dec_pkg::dec_pkt_t p;
  dec_pkg::fmt_e     f;
  p         = '0;
  p.op      = ref_op(inst);
  f         = ref_fmt(p.op);
  p.illegal = (f == dec_pkg::FMT_NONE);
  p.rs1_ren = f inside {dec_pkg::FMT_R, dec_pkg::FMT_I, dec_pkg::FMT_S, dec_pkg::FMT_B};
  p.rs2_ren = f inside {dec_pkg::FMT_R, dec_pkg::FMT_S, dec_pkg::FMT_B};
  p.rd_wen  = f inside {dec_pkg::FMT_R, dec_pkg::FMT_I, dec_pkg::FMT_U, dec_pkg::FMT_J};
  if (p.rs1_ren) begin
    p.rs1 = inst[19:15];
  end
  if (p.rs2_ren) begin
    p.rs2 = inst[24:20];
  end
  if (p.rd_wen) begin
    p.rd = inst[11:7];
  end
  case (f)
    dec_pkg::FMT_R, dec_pkg::FMT_S, dec_pkg::FMT_B: begin
      p.op1 = a;
      p.op2 = b;
      if (f == dec_pkg::FMT_S) begin
        p.op3 = sext(32'({inst[31:25], inst[11:7]}), 12);
      end else if (f == dec_pkg::FMT_B) begin
        p.op3 = pc + sext(32'({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}), 13);
      end
    end
    dec_pkg::FMT_I: begin
      p.op1 = a;
      if (p.op inside {[dec_pkg::OP_SLLI : dec_pkg::OP_SRAI]}) begin
        p.op2 = 64'(inst[25:20]);
      end else if (p.op inside {[dec_pkg::OP_SLLIW : dec_pkg::OP_SRAIW]}) begin
        p.op2 = 64'(inst[24:20]);
      end else begin
        p.op2 = sext(32'(inst[31:20]), 12);
      end
      if (p.op == dec_pkg::OP_JALR) begin
        p.op3 = pc + 64'd4;
      end else if (p.op inside {[dec_pkg::OP_LB : dec_pkg::OP_LWU]}) begin
        p.op3 = sext(32'(inst[31:20]), 12);
      end
    end
    dec_pkg::FMT_U: begin
      p.op1 = sext({inst[31:12], 12'h000}, 32);
      p.op2 = pc;
    end
    dec_pkg::FMT_J: begin
      p.op1 = pc;
      p.op2 = 64'd4;
      p.op3 = pc + sext(32'({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}), 21);
    end
    default: begin
    end
  endcase
  return p;
endfunction

`endif

/* dv/tb_decode.sv */
// random-traffic testbench for rv_decode_top with stalls on both sides
// and an in-order scoreboard fed by the reference model
module tb_decode;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LANES    = 3;
  localparam int NUM_PKTS     = 2000;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_CYCLES   = 20 * NUM_PKTS + RESET_CYCLES;

  logic                       clk;
  logic                       rst;
  logic                       i_valid;
  logic [dec_pkg::ILEN-1:0]   i_inst;
  logic [dec_pkg::XLEN-1:0]   i_pc;
  logic [dec_pkg::XLEN-1:0]   i_rs1_data;
  logic [dec_pkg::XLEN-1:0]   i_rs2_data;
  logic                       i_ready;
  logic                       o_ready;
  logic                       o_valid;
  dec_pkg::op_e               o_op;
  logic                       o_illegal;
  logic                       o_rs1_ren;
  logic [dec_pkg::RIDX_W-1:0] o_rs1;
  logic                       o_rs2_ren;
  logic [dec_pkg::RIDX_W-1:0] o_rs2;
  logic                       o_rd_wen;
  logic [dec_pkg::RIDX_W-1:0] o_rd;
  logic [dec_pkg::XLEN-1:0]   o_op1;
  logic [dec_pkg::XLEN-1:0]   o_op2;
  logic [dec_pkg::XLEN-1:0]   o_op3;

  dec_pkg::dec_pkt_t exp_q [$];
  logic [31:0]       rng_state = 32'h992b_12b8;
  logic              in_fire   = 1'b0;
  logic              out_fire  = 1'b0;
  int                n_recv    = 0;
  int                cycles    = 0;

  `include "decode_model.svh"

  rv_decode_top #(
    .NUM_LANES (NUM_LANES)
  ) uut (
    .clk        (clk),
    .rst        (rst),
    .i_valid    (i_valid),
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_ready    (o_ready),
    .o_valid    (o_valid),
    .i_ready    (i_ready),
    .o_op       (o_op),
    .o_illegal  (o_illegal),
    .o_rs1_ren  (o_rs1_ren),
    .o_rs1      (o_rs1),
    .o_rs2_ren  (o_rs2_ren),
    .o_rs2      (o_rs2),
    .o_rd_wen   (o_rd_wen),
    .o_rd       (o_rd),
    .o_op1      (o_op1),
    .o_op2      (o_op2),
    .o_op3      (o_op3)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // legal encoding, legal opcode with raw func3, or a fully random word
  function automatic logic [31:0] make_inst();
    logic [31:0] r;
    logic [6:0]  opc;
    logic [2:0]  f3;
    int          mode;
    r    = next_rand();
    mode = int'(next_rand() % 16);
    case (int'(next_rand() % 11))
      0:       opc = dec_pkg::OPC_LUI;
      1:       opc = dec_pkg::OPC_AUIPC;
      2:       opc = dec_pkg::OPC_JAL;
      3:       opc = dec_pkg::OPC_JALR;
      4:       opc = dec_pkg::OPC_BRANCH;
      5:       opc = dec_pkg::OPC_LOAD;
      6:       opc = dec_pkg::OPC_STORE;
      7:       opc = dec_pkg::OPC_OPIMM;
      8:       opc = dec_pkg::OPC_OP;
      9:       opc = dec_pkg::OPC_OPIMM32;
      default: opc = dec_pkg::OPC_OP32;
    endcase
    f3 = r[14:12];
    if (mode >= 4) begin
      case (opc)
        dec_pkg::OPC_JALR:   f3 = 3'b000;
        dec_pkg::OPC_BRANCH: f3[2] = f3[2] | f3[1];
        dec_pkg::OPC_LOAD:   f3 = (f3 == 3'b111) ? 3'b011 : f3;
        dec_pkg::OPC_STORE:  f3[2] = 1'b0;
        dec_pkg::OPC_OPIMM32, dec_pkg::OPC_OP32: begin
          f3 = (f3 inside {3'b000, 3'b001, 3'b101}) ? f3 : 3'b101;
        end
        default: begin
        end
      endcase
      if (opc inside {dec_pkg::OPC_OP, dec_pkg::OPC_OP32}) begin
        r[31:25] = {1'b0, r[30], 5'b00000};
      end
    end
    make_inst = (mode < 2) ? r : {r[31:15], f3, r[11:7], opc};
  endfunction

  task automatic load_packet();
    i_inst             = make_inst();
    i_pc[63:32]        = next_rand();
    i_pc[31:0]         = next_rand() & 32'hffff_fffc;
    i_rs1_data[63:32]  = next_rand();
    i_rs1_data[31:0]   = next_rand();
    i_rs2_data[63:32]  = next_rand();
    i_rs2_data[31:0]   = next_rand();
  endtask

  task automatic compare_output();
    dec_pkg::dec_pkt_t exp;
    if (exp_q.size() == 0) begin
      $display("DUT delivered a packet that was never sent");
      abort_run();
    end else begin
      exp = exp_q.pop_front();
      check_value("o_op", 64'(o_op), 64'(exp.op));
      check_value("o_illegal", 64'(o_illegal), 64'(exp.illegal));
      check_value("o_rs1_ren", 64'(o_rs1_ren), 64'(exp.rs1_ren));
      check_value("o_rs1", 64'(o_rs1), 64'(exp.rs1));
      check_value("o_rs2_ren", 64'(o_rs2_ren), 64'(exp.rs2_ren));
      check_value("o_rs2", 64'(o_rs2), 64'(exp.rs2));
      check_value("o_rd_wen", 64'(o_rd_wen), 64'(exp.rd_wen));
      check_value("o_rd", 64'(o_rd), 64'(exp.rd));
      check_value("o_op1", o_op1, exp.op1);
      check_value("o_op2", o_op2, exp.op2);
      check_value("o_op3", o_op3, exp.op3);
      n_recv++;
    end
  endtask

  // handshakes seen at mid-cycle complete on the next rising edge
  always @(negedge clk) begin
    in_fire  = !rst && i_valid && o_ready;
    out_fire = !rst && o_valid && i_ready;
    // packets held in the lanes decide both handshake outputs
    if (!rst) begin
      check_value("o_valid", 64'(o_valid), 64'(exp_q.size() != 0));
      check_value("o_ready", 64'(o_ready), 64'((exp_q.size() < NUM_LANES) || i_ready));
    end
    if (out_fire) begin
      compare_output();
    end
    if (in_fire) begin
      exp_q.push_back(decode_ref(i_inst, i_pc, i_rs1_data, i_rs2_data));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  task automatic run_traffic();
    int n_sent;
    n_sent = 0;
    while (n_recv < NUM_PKTS) begin
      @(posedge clk);
      #1;
      if (in_fire) begin
        n_sent++;
        i_valid = 1'b0;
      end
      if (!i_valid && n_sent < NUM_PKTS && next_rand() % 4 != 0) begin
        load_packet();
        i_valid = 1'b1;
      end
      i_ready = (next_rand() % 4 != 0);
    end
  endtask

  initial begin
    rst        = 1'b1;
    i_valid    = 1'b0;
    i_inst     = '0;
    i_pc       = '0;
    i_rs1_data = '0;
    i_rs2_data = '0;
    i_ready    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst     = 1'b0;
    i_ready = 1'b1;
    // empty pipeline right after reset
    repeat (4) begin
      @(negedge clk);
      check_value("o_valid", 64'(o_valid), 64'd0);
    end
    run_traffic();
    i_ready = 1'b1;
    // no stray packets once all are delivered
    repeat (8) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d accepted packets never left the DUT", exp_q.size());
      abort_run();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

/* source/rv_decode_top.sv */
// RV64I decode top: dispatcher, decode lanes and collector
// with plain ports on both sides
module rv_decode_top #(
  parameter int NUM_LANES = 3
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_valid,
  input  logic [dec_pkg::ILEN-1:0]   i_inst,
  input  logic [dec_pkg::XLEN-1:0]   i_pc,
  input  logic [dec_pkg::XLEN-1:0]   i_rs1_data,
  input  logic [dec_pkg::XLEN-1:0]   i_rs2_data,
  output logic                       o_ready,
  output logic                       o_valid,
  input  logic                       i_ready,
  output dec_pkg::op_e               o_op,
  output logic                       o_illegal,
  output logic                       o_rs1_ren,
  output logic [dec_pkg::RIDX_W-1:0] o_rs1,
  output logic                       o_rs2_ren,
  output logic [dec_pkg::RIDX_W-1:0] o_rs2,
  output logic                       o_rd_wen,
  output logic [dec_pkg::RIDX_W-1:0] o_rd,
  output logic [dec_pkg::XLEN-1:0]   o_op1,
  output logic [dec_pkg::XLEN-1:0]   o_op2,
  output logic [dec_pkg::XLEN-1:0]   o_op3
);

  dec_pkg::fetch_pkt_t in_pkt;
  dec_pkg::dec_pkt_t   out_pkt;

  dec_stream_if #(.T(dec_pkg::fetch_pkt_t)) lane_in  [NUM_LANES] ();
  dec_stream_if #(.T(dec_pkg::dec_pkt_t))   lane_out [NUM_LANES] ();

  assign in_pkt.inst     = i_inst;
  assign in_pkt.pc       = i_pc;
  assign in_pkt.rs1_data = i_rs1_data;
  assign in_pkt.rs2_data = i_rs2_data;

  dec_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .clk     (clk),
    .rst     (rst),
    .i_valid (i_valid),
    .i_pkt   (in_pkt),
    .o_ready (o_ready),
    .lanes   (lane_in)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    dec_lane u_lane (
      .clk   (clk),
      .rst   (rst),
      .in_s  (lane_in[g]),
      .out_s (lane_out[g])
    );
  end

  dec_collect #(
    .NUM_LANES (NUM_LANES)
  ) u_collect (
    .clk     (clk),
    .rst     (rst),
    .i_ready (i_ready),
    .lanes   (lane_out),
    .o_valid (o_valid),
    .o_pkt   (out_pkt)
  );

  assign o_op      = out_pkt.op;
  assign o_illegal = out_pkt.illegal;
  assign o_rs1_ren = out_pkt.rs1_ren;
  assign o_rs1     = out_pkt.rs1;
  assign o_rs2_ren = out_pkt.rs2_ren;
  assign o_rs2     = out_pkt.rs2;
  assign o_rd_wen  = out_pkt.rd_wen;
  assign o_rd      = out_pkt.rd;
  assign o_op1     = out_pkt.op1;
  assign o_op2     = out_pkt.op2;
  assign o_op3     = out_pkt.op3;

endmodule

/* source/dec_collect.sv */
// in-order round-robin drain of the lanes to the decode output
module dec_collect #(
  parameter int NUM_LANES = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_ready,
  dec_stream_if.snk         lanes [NUM_LANES],
  output logic              o_valid,
  output dec_pkg::dec_pkt_t o_pkt
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [PTR_W-1:0]     ptr;
  logic [NUM_LANES-1:0] lane_valid;
  dec_pkg::dec_pkt_t    lane_data [NUM_LANES];

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane_valid[g]  = lanes[g].valid;
    assign lane_data[g]   = lanes[g].data;
    assign lanes[g].ready = i_ready && (ptr == PTR_W'(g));
  end

  assign o_valid = lane_valid[ptr];
  assign o_pkt   = lane_data[ptr];

  // follows the dispatch order
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (o_valid && i_ready) begin
      if (ptr == PTR_W'(NUM_LANES - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // lanes fill in pointer order, so any full lane means the pointed one is full
  a_in_order: assert property (@(posedge clk) disable iff (rst)
    (|lane_valid) |-> lane_valid[ptr]);

endmodule

/* source/dec_lane.sv */
// one decode lane with immediates, operand selection
// and a one-entry output register
module dec_lane (
  input  logic      clk,
  input  logic      rst,
  dec_stream_if.snk in_s,
  dec_stream_if.src out_s
);

  localparam logic [dec_pkg::XLEN-1:0] INST_BYTES = 4;

  dec_pkg::fetch_pkt_t       in_pkt;
  dec_pkg::dec_pkt_t         dec_d;
  dec_pkg::dec_pkt_t         out_q;
  dec_pkg::op_e              op;
  dec_pkg::fmt_e             fmt;
  logic [dec_pkg::ILEN-1:0]  inst;
  logic [dec_pkg::XLEN-1:0]  imm_i;
  logic [dec_pkg::XLEN-1:0]  imm_s;
  logic [dec_pkg::XLEN-1:0]  imm_b;
  logic [dec_pkg::XLEN-1:0]  imm_u;
  logic [dec_pkg::XLEN-1:0]  imm_j;
  logic                      is_sh64;
  logic                      is_sh32;
  logic                      is_load;
  logic                      full_q;
  logic                      in_rdy;

  assign in_pkt = in_s.data;
  assign inst   = in_pkt.inst;

  dec_classify u_classify (
    .i_inst (inst),
    .o_op   (op),
    .o_fmt  (fmt)
  );

  assign imm_i = {{(dec_pkg::XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(dec_pkg::XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(dec_pkg::XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                  inst[11:8], 1'b0};
  assign imm_u = {{(dec_pkg::XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(dec_pkg::XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};

  assign is_sh64 = op inside {dec_pkg::OP_SLLI, dec_pkg::OP_SRLI, dec_pkg::OP_SRAI};
  assign is_sh32 = op inside {dec_pkg::OP_SLLIW, dec_pkg::OP_SRLIW, dec_pkg::OP_SRAIW};
  assign is_load = op inside {dec_pkg::OP_LB, dec_pkg::OP_LH, dec_pkg::OP_LW, dec_pkg::OP_LD,
                              dec_pkg::OP_LBU, dec_pkg::OP_LHU, dec_pkg::OP_LWU};

  // unnamed fields stay zero, illegal gets op and flag only
  always_comb begin
    dec_d         = '0;
    dec_d.op      = op;
    dec_d.illegal = (op == dec_pkg::OP_ILLEGAL);
    dec_d.rs1_ren = fmt inside {dec_pkg::FMT_R, dec_pkg::FMT_I, dec_pkg::FMT_S, dec_pkg::FMT_B};
    dec_d.rs2_ren = fmt inside {dec_pkg::FMT_R, dec_pkg::FMT_S, dec_pkg::FMT_B};
    dec_d.rd_wen  = fmt inside {dec_pkg::FMT_R, dec_pkg::FMT_I, dec_pkg::FMT_U, dec_pkg::FMT_J};
    dec_d.rs1     = dec_d.rs1_ren ? inst[19:15] : '0;
    dec_d.rs2     = dec_d.rs2_ren ? inst[24:20] : '0;
    dec_d.rd      = dec_d.rd_wen ? inst[11:7] : '0;
    case (fmt)
      dec_pkg::FMT_R: begin
        dec_d.op1 = in_pkt.rs1_data;
        dec_d.op2 = in_pkt.rs2_data;
      end
      dec_pkg::FMT_I: begin
        dec_d.op1 = in_pkt.rs1_data;
        if (is_sh64) begin
          dec_d.op2 = {{(dec_pkg::XLEN-6){1'b0}}, inst[25:20]};
        end else if (is_sh32) begin
          dec_d.op2 = {{(dec_pkg::XLEN-5){1'b0}}, inst[24:20]};
        end else begin
          dec_d.op2 = imm_i;
        end
        if (op == dec_pkg::OP_JALR) begin
          dec_d.op3 = in_pkt.pc + INST_BYTES;
        end else if (is_load) begin
          dec_d.op3 = imm_i;
        end
      end
      dec_pkg::FMT_S: begin
        dec_d.op1 = in_pkt.rs1_data;
        dec_d.op2 = in_pkt.rs2_data;
        dec_d.op3 = imm_s;
      end
      dec_pkg::FMT_B: begin
        dec_d.op1 = in_pkt.rs1_data;
        dec_d.op2 = in_pkt.rs2_data;
        dec_d.op3 = in_pkt.pc + imm_b;
      end
      dec_pkg::FMT_U: begin
        dec_d.op1 = imm_u;
        dec_d.op2 = in_pkt.pc;
      end
      dec_pkg::FMT_J: begin
        dec_d.op1 = in_pkt.pc;
        dec_d.op2 = INST_BYTES;
        dec_d.op3 = in_pkt.pc + imm_j;
      end
      default: begin
      end
    endcase
  end

  // accept when empty or draining this cycle
  assign in_rdy     = !full_q || out_s.ready;
  assign in_s.ready = in_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (in_s.valid && in_rdy) begin
      full_q <= 1'b1;
    end else if (out_s.ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_s.valid && in_rdy) begin
      out_q <= dec_d;
    end
  end

  assign out_s.valid = full_q;
  assign out_s.data  = out_q;

  a_hold: assert property (@(posedge clk) disable iff (rst)
    full_q && !out_s.ready |=> full_q && $stable(out_q));

endmodule

/* source/dec_classify.sv */
// opcode/func3/func7 decoding into an operation and a format
module dec_classify (
  input  logic [dec_pkg::ILEN-1:0] i_inst,
  output dec_pkg::op_e             o_op,
  output dec_pkg::fmt_e            o_fmt
);

  logic [6:0]     opc;
  logic [2:0]     f3;
  logic           f7b5;
  dec_pkg::op_e   op;
  dec_pkg::fmt_e  grp_fmt;

  // bits 1..0 not checked
  assign opc  = {i_inst[6:2], 2'b11};
  assign f3   = i_inst[14:12];
  assign f7b5 = i_inst[30];

  always_comb begin
    op      = dec_pkg::OP_ILLEGAL;
    grp_fmt = dec_pkg::FMT_NONE;
    case (opc)
      dec_pkg::OPC_LUI: begin
        op      = dec_pkg::OP_LUI;
        grp_fmt = dec_pkg::FMT_U;
      end
      dec_pkg::OPC_AUIPC: begin
        op      = dec_pkg::OP_AUIPC;
        grp_fmt = dec_pkg::FMT_U;
      end
      dec_pkg::OPC_JAL: begin
        op      = dec_pkg::OP_JAL;
        grp_fmt = dec_pkg::FMT_J;
      end
      dec_pkg::OPC_JALR: begin
        grp_fmt = dec_pkg::FMT_I;
        if (f3 == 3'b000) begin
          op = dec_pkg::OP_JALR;
        end
      end
      dec_pkg::OPC_BRANCH: begin
        grp_fmt = dec_pkg::FMT_B;
        case (f3)
          3'b000:  op = dec_pkg::OP_BEQ;
          3'b001:  op = dec_pkg::OP_BNE;
          3'b100:  op = dec_pkg::OP_BLT;
          3'b101:  op = dec_pkg::OP_BGE;
          3'b110:  op = dec_pkg::OP_BLTU;
          3'b111:  op = dec_pkg::OP_BGEU;
          default: op = dec_pkg::OP_ILLEGAL;
        endcase
      end
      dec_pkg::OPC_LOAD: begin
        grp_fmt = dec_pkg::FMT_I;
        case (f3)
          3'b000:  op = dec_pkg::OP_LB;
          3'b001:  op = dec_pkg::OP_LH;
          3'b010:  op = dec_pkg::OP_LW;
          3'b011:  op = dec_pkg::OP_LD;
          3'b100:  op = dec_pkg::OP_LBU;
          3'b101:  op = dec_pkg::OP_LHU;
          3'b110:  op = dec_pkg::OP_LWU;
          default: op = dec_pkg::OP_ILLEGAL;
        endcase
      end
      dec_pkg::OPC_STORE: begin
        grp_fmt = dec_pkg::FMT_S;
        case (f3)
          3'b000:  op = dec_pkg::OP_SB;
          3'b001:  op = dec_pkg::OP_SH;
          3'b010:  op = dec_pkg::OP_SW;
          3'b011:  op = dec_pkg::OP_SD;
          default: op = dec_pkg::OP_ILLEGAL;
        endcase
      end
      dec_pkg::OPC_OPIMM: begin
        grp_fmt = dec_pkg::FMT_I;
        case (f3)
          3'b000:  op = dec_pkg::OP_ADDI;
          3'b001:  op = dec_pkg::OP_SLLI;
          3'b010:  op = dec_pkg::OP_SLTI;
          3'b011:  op = dec_pkg::OP_SLTIU;
          3'b100:  op = dec_pkg::OP_XORI;
          3'b101:  op = f7b5 ? dec_pkg::OP_SRAI : dec_pkg::OP_SRLI;
          3'b110:  op = dec_pkg::OP_ORI;
          default: op = dec_pkg::OP_ANDI;
        endcase
      end
      dec_pkg::OPC_OP: begin
        grp_fmt = dec_pkg::FMT_R;
        case (f3)
          3'b000:  op = f7b5 ? dec_pkg::OP_SUB : dec_pkg::OP_ADD;
          3'b001:  op = dec_pkg::OP_SLL;
          3'b010:  op = dec_pkg::OP_SLT;
          3'b011:  op = dec_pkg::OP_SLTU;
          3'b100:  op = dec_pkg::OP_XOR;
          3'b101:  op = f7b5 ? dec_pkg::OP_SRA : dec_pkg::OP_SRL;
          3'b110:  op = dec_pkg::OP_OR;
          default: op = dec_pkg::OP_AND;
        endcase
      end
      dec_pkg::OPC_OPIMM32: begin
        grp_fmt = dec_pkg::FMT_I;
        case (f3)
          3'b000:  op = dec_pkg::OP_ADDIW;
          3'b001:  op = dec_pkg::OP_SLLIW;
          3'b101:  op = f7b5 ? dec_pkg::OP_SRAIW : dec_pkg::OP_SRLIW;
          default: op = dec_pkg::OP_ILLEGAL;
        endcase
      end
      dec_pkg::OPC_OP32: begin
        grp_fmt = dec_pkg::FMT_R;
        case (f3)
          3'b000:  op = f7b5 ? dec_pkg::OP_SUBW : dec_pkg::OP_ADDW;
          3'b001:  op = dec_pkg::OP_SLLW;
          3'b101:  op = f7b5 ? dec_pkg::OP_SRAW : dec_pkg::OP_SRLW;
          default: op = dec_pkg::OP_ILLEGAL;
        endcase
      end
      default: begin
        op      = dec_pkg::OP_ILLEGAL;
        grp_fmt = dec_pkg::FMT_NONE;
      end
    endcase
  end

  assign o_op  = op;
  assign o_fmt = (op == dec_pkg::OP_ILLEGAL) ? dec_pkg::FMT_NONE : grp_fmt;

endmodule

/* source/dec_dispatch.sv */
// round-robin dispatcher from the decode input to the lanes
module dec_dispatch #(
  parameter int NUM_LANES = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_valid,
  input  dec_pkg::fetch_pkt_t i_pkt,
  output logic                o_ready,
  dec_stream_if.src           lanes [NUM_LANES]
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [PTR_W-1:0]     ptr;
  logic [NUM_LANES-1:0] lane_valid;
  logic [NUM_LANES-1:0] lane_ready;

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane_valid[g]  = i_valid && (ptr == PTR_W'(g));
    assign lanes[g].valid = lane_valid[g];
    assign lanes[g].data  = i_pkt;
    assign lane_ready[g]  = lanes[g].ready;
  end

  assign o_ready = lane_ready[ptr];

  // next lane after every accepted packet
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (i_valid && o_ready) begin
      if (ptr == PTR_W'(NUM_LANES - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // pointer always names an existing lane
  a_ptr_range: assert property (@(posedge clk) disable iff (rst)
    32'(ptr) < NUM_LANES);

endmodule

/* source/dec_stream_if.sv */
// valid/ready stream interface with a typed payload
// and source/sink modports
interface dec_stream_if #(
  parameter type T = logic
);

  logic valid;
  logic ready;
  T     data;

  modport src (
    output valid,
    output data,
    input  ready
  );

  modport snk (
    input  valid,
    input  data,
    output ready
  );

endinterface

/* source/dec_pkg.sv */
// shared widths, operation and format enums, decode packet structs
// and the major opcode constants
package dec_pkg;

  parameter int XLEN   = 64;
  parameter int ILEN   = 32;
  parameter int RIDX_W = 5;

  // major opcodes
  parameter logic [6:0] OPC_LUI     = 7'b0110111;
  parameter logic [6:0] OPC_AUIPC   = 7'b0010111;
  parameter logic [6:0] OPC_JAL     = 7'b1101111;
  parameter logic [6:0] OPC_JALR    = 7'b1100111;
  parameter logic [6:0] OPC_BRANCH  = 7'b1100011;
  parameter logic [6:0] OPC_LOAD    = 7'b0000011;
  parameter logic [6:0] OPC_STORE   = 7'b0100011;
  parameter logic [6:0] OPC_OPIMM   = 7'b0010011;
  parameter logic [6:0] OPC_OP      = 7'b0110011;
  parameter logic [6:0] OPC_OPIMM32 = 7'b0011011;
  parameter logic [6:0] OPC_OP32    = 7'b0111011;

  // 50 operations, needs 6 bits
  typedef enum logic [5:0] {
    OP_ILLEGAL,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
    OP_SB, OP_SH, OP_SW, OP_SD,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW
  } op_e;

  typedef enum logic [2:0] {
    FMT_NONE, FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
  } fmt_e;

  typedef struct packed {
    logic [ILEN-1:0] inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
  } fetch_pkt_t;

  typedef struct packed {
    op_e               op;
    logic              rs1_ren;
    logic [RIDX_W-1:0] rs1;
    logic              rs2_ren;
    logic [RIDX_W-1:0] rs2;
    logic              rd_wen;
    logic [RIDX_W-1:0] rd;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;
    logic [XLEN-1:0]   op3;
    logic              illegal;
  } dec_pkt_t;

endpackage
